// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_core
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module rv_core (
	input  logic               clk_i,
	input  logic               reset_i,
	input  rv_isa_pkg::instr_t instr_i,
	input  rv_isa_pkg::word_t  data_rdata_i,
	input  logic               data_stall_i,
	output rv_isa_pkg::word_t  instr_addr_o,
	output logic               data_req_o,
	output logic               data_we_o,
	output rv_isa_pkg::word_t  data_addr_o,
	output rv_isa_pkg::word_t  data_wdata_o
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	localparam if_id_t if_id_bubble = '{pc: `RESET_VECTOR, instr: `NOP_INSTR, valid: 1'b0};

	word_t    pc;
	if_id_t   if_id;
	id_ex_t   id_ex;
	ex_mem_t  ex_mem;
	mem_wb_t  mem_wb;

	ctrl_t     dec_ctrl;
	reg_addr_t dec_rs1;
	reg_addr_t dec_rs2;
	reg_addr_t dec_rd;
	word_t     dec_imm;
	word_t     rf_data1;
	word_t     rf_data2;

	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	logic     load_use_stall;
	word_t    alu_result;
	word_t    store_data;
	word_t    branch_target;
	logic     take_branch;

	word_t ex_mem_value; // what EX/MEM will write back
	word_t wb_value;

	assign instr_addr_o = pc;

	// priority: data stall, then branch flush, then load-use bubble
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			pc <= `RESET_VECTOR;
		else if (!data_stall_i)
		begin
			if (take_branch)
				pc <= branch_target;
			else if (!load_use_stall)
				pc <= pc + word_t'(4);
		end
	end

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			if_id <= if_id_bubble;
		else if (!data_stall_i)
		begin
			if (take_branch)
				if_id <= if_id_bubble; // younger fetch is off-path
			else if (!load_use_stall)
				if_id <= '{pc: pc, instr: instr_i, valid: 1'b1};
		end
	end

	rv_decoder u_decoder (
		.instr_i (if_id.instr),
		.valid_i (if_id.valid),
		.ctrl_o  (dec_ctrl),
		.rs1_o   (dec_rs1),
		.rs2_o   (dec_rs2),
		.rd_o    (dec_rd),
		.imm_o   (dec_imm)
	);

	rv_regfile u_regfile (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.rs1_i    (dec_rs1),
		.rs2_i    (dec_rs2),
		.we_i     (mem_wb.reg_write),
		.rd_i     (mem_wb.rd),
		.wdata_i  (wb_value),
		.rdata1_o (rf_data1),
		.rdata2_o (rf_data2)
	);

	rv_hazard_unit u_hazard (
		.id_rs1_i         (dec_rs1),
		.id_rs2_i         (dec_rs2),
		.id_ex_i          (id_ex),
		.ex_mem_i         (ex_mem),
		.mem_wb_i         (mem_wb),
		.fwd_a_o          (fwd_a),
		.fwd_b_o          (fwd_b),
		.load_use_stall_o (load_use_stall)
	);

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			id_ex <= '0;
		else if (!data_stall_i)
		begin
			if (take_branch || load_use_stall)
				id_ex <= '0; // bubble into execute
			else
				id_ex <= '{pc: if_id.pc, rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd,
					op_a: rf_data1, op_b: rf_data2, imm: dec_imm, ctrl: dec_ctrl};
		end
	end

	rv_execute u_execute (
		.id_ex_i         (id_ex),
		.fwd_a_i         (fwd_a),
		.fwd_b_i         (fwd_b),
		.ex_mem_result_i (ex_mem_value),
		.wb_value_i      (wb_value),
		.alu_result_o    (alu_result),
		.store_data_o    (store_data),
		.target_o        (branch_target),
		.take_branch_o   (take_branch)
	);

	// data port straight from execute
	assign data_req_o   = id_ex.ctrl.mem_read | id_ex.ctrl.mem_write;
	assign data_we_o    = id_ex.ctrl.mem_write;
	assign data_addr_o  = alu_result;
	assign data_wdata_o = store_data;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			ex_mem <= '0;
		else if (!data_stall_i)
			ex_mem <= '{rd: id_ex.rd, alu_result: alu_result, link: id_ex.pc + word_t'(4),
				mem_read: id_ex.ctrl.mem_read, reg_write: id_ex.ctrl.reg_write,
				wb_sel: id_ex.ctrl.wb_sel};
	end

	assign ex_mem_value = (ex_mem.wb_sel == WB_LINK) ? ex_mem.link : ex_mem.alu_result;

	// load data is valid during the memory stage, sampled here
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			mem_wb <= '0;
		else if (!data_stall_i)
			mem_wb <= '{rd: ex_mem.rd, result: ex_mem_value, load_data: data_rdata_i,
				reg_write: ex_mem.reg_write, wb_sel: ex_mem.wb_sel};
	end

	always_comb
	begin
		case (mem_wb.wb_sel)
			WB_MEM:  wb_value = mem_wb.load_data;
			default: wb_value = mem_wb.result; // alu or link, merged in MEM
		endcase
	end

endmodule

`default_nettype wire

// ==== design/rv_core_defs.svh ====
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// data and address width
`define XLEN 32

// architectural integer registers, x0 included
`define REG_COUNT 32

// first fetch address after reset
`define RESET_VECTOR 32'h0000_0000

// addi x0,x0,0
`define NOP_INSTR 32'h0000_0013

`endif

// ==== design/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  rv_isa_pkg::instr_t    instr_i,
	input  logic                  valid_i,
	output rv_pipe_pkg::ctrl_t    ctrl_o,
	output rv_isa_pkg::reg_addr_t rs1_o,
	output rv_isa_pkg::reg_addr_t rs2_o,
	output rv_isa_pkg::reg_addr_t rd_o,
	output rv_isa_pkg::word_t     imm_o
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	alu_op_e    f3_op;   // alu op implied by funct3
	logic       f3_ok;
	ctrl_t      ctrl;
	word_t      imm;
	logic       use_rs1;
	logic       use_rs2;
	logic       legal;
	logic       active;

	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	always_comb
	begin
		case (instr_i[6:0])
			OPC_LUI, OPC_OP_IMM, OPC_OP, OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL:
				opcode = opcode_e'(instr_i[6:0]);
			default:
				opcode = OPC_OTHER;
		endcase
	end

	// shared by op and op-imm
	always_comb
	begin
		f3_ok = 1'b1;
		case (funct3)
			3'b000: f3_op = ALU_ADD;
			3'b010: f3_op = ALU_SLT;
			3'b100: f3_op = ALU_XOR;
			3'b110: f3_op = ALU_OR;
			3'b111: f3_op = ALU_AND;
			default:
			begin
				f3_op = ALU_ADD;
				f3_ok = 1'b0; // shifts and sltu are not supported
			end
		endcase
	end

	always_comb
	begin
		ctrl    = '0;
		imm     = '0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		legal   = 1'b1;
		case (opcode)
			OPC_LUI:
			begin
				ctrl.alu_op    = ALU_PASS_B;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = {instr_i[31:12], 12'b0};
			end
			OPC_OP_IMM:
			begin
				ctrl.alu_op    = f3_op;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				use_rs1 = 1'b1;
				imm   = {{20{instr_i[31]}}, instr_i[31:20]};
				legal = f3_ok;
			end
			OPC_OP:
			begin
				ctrl.alu_op    = funct7[5] ? ALU_SUB : f3_op;
				ctrl.reg_write = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				legal   = f3_ok && (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000));
			end
			OPC_LOAD:
			begin
				ctrl.use_imm   = 1'b1; // address = rs1 + imm
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.wb_sel    = WB_MEM;
				use_rs1 = 1'b1;
				imm   = {{20{instr_i[31]}}, instr_i[31:20]};
				legal = (funct3 == 3'b010); // lw only
			end
			OPC_STORE:
			begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				imm   = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
				legal = (funct3 == 3'b010); // sw only
			end
			OPC_BRANCH:
			begin
				ctrl.branch    = 1'b1;
				ctrl.branch_ne = funct3[0];
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
					instr_i[11:8], 1'b0};
				legal = (funct3[2:1] == 2'b00);
			end
			OPC_JAL:
			begin
				ctrl.jump      = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_LINK;
				imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
					instr_i[30:21], 1'b0};
			end
			default:
				legal = 1'b0;
		endcase
	end

	assign active = valid_i & legal;
	assign ctrl_o = active ? ctrl : '0; // unsupported words become a bubble

	// unused sources read as x0 so they never trigger a stall
	assign rs1_o = (active && use_rs1) ? instr_i[19:15] : '0;
	assign rs2_o = (active && use_rs2) ? instr_i[24:20] : '0;
	assign rd_o  = instr_i[11:7];
	assign imm_o = imm;

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	input  rv_pipe_pkg::id_ex_t   id_ex_i,
	input  rv_pipe_pkg::fwd_sel_e fwd_a_i,
	input  rv_pipe_pkg::fwd_sel_e fwd_b_i,
	input  rv_isa_pkg::word_t     ex_mem_result_i,
	input  rv_isa_pkg::word_t     wb_value_i,
	output rv_isa_pkg::word_t     alu_result_o,
	output rv_isa_pkg::word_t     store_data_o,
	output rv_isa_pkg::word_t     target_o,
	output logic                  take_branch_o
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	word_t src_a;
	word_t src_b;
	word_t alu_b;
	logic  equal;

	function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf_val, word_t ex_mem_val,
		word_t wb_val);
		case (sel)
			FWD_EX_MEM: return ex_mem_val;
			FWD_MEM_WB: return wb_val;
			default:    return rf_val;
		endcase
	endfunction

	assign src_a = fwd_mux(fwd_a_i, id_ex_i.op_a, ex_mem_result_i, wb_value_i);
	assign src_b = fwd_mux(fwd_b_i, id_ex_i.op_b, ex_mem_result_i, wb_value_i);
	assign alu_b = id_ex_i.ctrl.use_imm ? id_ex_i.imm : src_b;

	always_comb
	begin
		case (id_ex_i.ctrl.alu_op)
			ALU_ADD:    alu_result_o = src_a + alu_b;
			ALU_SUB:    alu_result_o = src_a - alu_b;
			ALU_AND:    alu_result_o = src_a & alu_b;
			ALU_OR:     alu_result_o = src_a | alu_b;
			ALU_XOR:    alu_result_o = src_a ^ alu_b;
			ALU_SLT:    alu_result_o = word_t'($signed(src_a) < $signed(alu_b));
			ALU_PASS_B: alu_result_o = alu_b;
			default:    alu_result_o = '0;
		endcase
	end

	assign store_data_o = src_b; // rs2 after forwarding

	// beq/bne compare the forwarded registers, not the alu output
	assign equal  = (src_a == src_b);
	assign target_o = id_ex_i.pc + id_ex_i.imm; // branch and jal alike
	assign take_branch_o = id_ex_i.ctrl.jump |
		(id_ex_i.ctrl.branch & (equal ^ id_ex_i.ctrl.branch_ne));

endmodule

`default_nettype wire

// ==== design/rv_hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit (
	input  rv_isa_pkg::reg_addr_t  id_rs1_i,
	input  rv_isa_pkg::reg_addr_t  id_rs2_i,
	input  rv_pipe_pkg::id_ex_t    id_ex_i,
	input  rv_pipe_pkg::ex_mem_t   ex_mem_i,
	input  rv_pipe_pkg::mem_wb_t   mem_wb_i,
	output rv_pipe_pkg::fwd_sel_e  fwd_a_o,
	output rv_pipe_pkg::fwd_sel_e  fwd_b_o,
	output logic                   load_use_stall_o
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	function automatic fwd_sel_e pick_source(reg_addr_t src, ex_mem_t ex_mem, mem_wb_t mem_wb);
		fwd_sel_e sel;
		sel = FWD_RF;
		if (src != '0 && mem_wb.reg_write && mem_wb.rd == src)
			sel = FWD_MEM_WB;
		// newer writer wins, a load in EX/MEM has no data yet
		if (src != '0 && ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd == src)
			sel = FWD_EX_MEM;
		return sel;
	endfunction

	assign fwd_a_o = pick_source(id_ex_i.rs1, ex_mem_i, mem_wb_i);
	assign fwd_b_o = pick_source(id_ex_i.rs2, ex_mem_i, mem_wb_i);

	// load in execute feeding the instruction in decode
	assign load_use_stall_o = id_ex_i.ctrl.mem_read && id_ex_i.rd != '0 &&
		(id_ex_i.rd == id_rs1_i || id_ex_i.rd == id_rs2_i);

endmodule

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

`include "rv_core_defs.svh"

package rv_isa_pkg;

	typedef logic [`XLEN-1:0] word_t;    // data or address
	typedef logic [4:0]       reg_addr_t;
	typedef logic [31:0]      instr_t;

	// major opcodes, values are the instr[6:0] encodings
	typedef enum logic [6:0]
	{
		OPC_LUI    = 7'b0110111,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_OTHER  = 7'b0000000  // anything not in the subset
	} opcode_e;

	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B  // lui
	} alu_op_e;

endpackage

`default_nettype wire

// ==== design/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

	import rv_isa_pkg::*;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

	// where an execute operand comes from
	typedef enum logic [1:0] {FWD_RF, FWD_EX_MEM, FWD_MEM_WB} fwd_sel_e;

	// all zero means an inactive instruction
	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;   // immediate replaces rs2 at the alu
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    branch;
		logic    branch_ne; // bne when set, beq otherwise
		logic    jump;
		wb_sel_e wb_sel;
	} ctrl_t;

	typedef struct packed {
		word_t  pc;
		instr_t instr;
		logic   valid;
	} if_id_t;

	typedef struct packed {
		word_t     pc;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     op_a;
		word_t     op_b;
		word_t     imm;
		ctrl_t     ctrl;
	} id_ex_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t     alu_result; // also the data address
		word_t     link;       // pc + 4 for jal
		logic      mem_read;
		logic      reg_write;
		wb_sel_e   wb_sel;
	} ex_mem_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t     result;     // alu result or link
		word_t     load_data;
		logic      reg_write;
		wb_sel_e   wb_sel;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module rv_regfile (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  rv_isa_pkg::reg_addr_t rs1_i,
	input  rv_isa_pkg::reg_addr_t rs2_i,
	input  logic                  we_i,
	input  rv_isa_pkg::reg_addr_t rd_i,
	input  rv_isa_pkg::word_t     wdata_i,
	output rv_isa_pkg::word_t     rdata1_o,
	output rv_isa_pkg::word_t     rdata2_o
);
	import rv_isa_pkg::*;

	word_t regs [1:`REG_COUNT-1]; // no storage for x0

	// written on the falling edge so decode sees the value in the same cycle
	always_ff @(negedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			for (int i = 1; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (we_i && rd_i != '0)
		begin
			regs[rd_i] <= wdata_i;
		end
	end

	assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_hazard_unit.sv
design/rv_execute.sv
design/rv_core.sv
sim/rv_core_checker.sv
sim/rv_core_properties.sv
sim/tb_rv_core.sv

// ==== sim/rv_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module rv_core_checker (
	input logic              clk_i,
	input logic              reset_i,
	input rv_isa_pkg::word_t instr_addr_i,
	input logic              data_req_i,
	input logic              data_we_i,
	input rv_isa_pkg::word_t data_addr_i,
	input rv_isa_pkg::word_t data_wdata_i,
	input logic              data_stall_i
);
	import rv_isa_pkg::*;

	word_t exp_addr [$];
	word_t exp_data [$];
	int    seen;    // stores matched so far in this test
	int    errors;
	logic  fetch_checked; // first fetch address already compared

	task automatic clear_expected();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic expect_store(word_t addr, word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	always @(posedge clk_i)
	begin
		if (!reset_i)
		begin
			seen          = 0;
			errors        = 0;
			fetch_checked = 1'b0;
		end
		else
		begin
			// pc still holds its reset value at the first edge out of reset
			if (!fetch_checked)
			begin
				if (instr_addr_i !== `RESET_VECTOR)
				begin
					$display("FAIL instr_addr_o first fetch expected %h got %h",
						`RESET_VECTOR, instr_addr_i);
					errors++;
				end
				fetch_checked = 1'b1;
			end
			// a store counts when the request is high with no stall
			if (data_req_i && data_we_i && !data_stall_i)
			begin
				if (seen >= exp_addr.size())
				begin
					$display("unexpected extra store of %h to address %h",
						data_wdata_i, data_addr_i);
					errors++;
				end
				else
				begin
					if (data_addr_i !== exp_addr[seen])
					begin
						$display("FAIL data_addr_o store %0d expected %h got %h", seen,
							exp_addr[seen], data_addr_i);
						errors++;
					end
					if (data_wdata_i !== exp_data[seen])
					begin
						$display("FAIL data_wdata_o store %0d expected %h got %h", seen,
							exp_data[seen], data_wdata_i);
						errors++;
					end
					seen++;
				end
			end
		end
	end

	task automatic finish_test(output int errs);
		int missing;
		missing = exp_addr.size() - seen;
		if (missing > 0)
			$display("%0d expected store(s) never appeared on the data port", missing);
		errs = errors + ((missing > 0) ? missing : 0);
	endtask

endmodule

`default_nettype wire

// ==== sim/rv_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties (
	input logic              clk_i,
	input logic              reset_i,
	input logic              data_stall_i,
	input rv_isa_pkg::word_t instr_addr_o,
	input logic              data_req_o,
	input logic              data_we_o,
	input rv_isa_pkg::word_t data_addr_o,
	input rv_isa_pkg::word_t data_wdata_o
);
	import rv_isa_pkg::*;

	we_needs_req: assert property (@(posedge clk_i) disable iff (!reset_i)
		data_we_o |-> data_req_o)
		else $error("data_we_o high without data_req_o");

	quiet_after_reset: assert property (@(posedge clk_i)
		$rose(reset_i) |-> (!data_req_o && !data_we_o))
		else $error("data port active in the first cycle after reset");

	fetch_aligned: assert property (@(posedge clk_i) disable iff (!reset_i)
		instr_addr_o[1:0] == 2'b00)
		else $error("instr_addr_o not word aligned");

	// pipeline frozen, request held
	hold_on_stall: assert property (@(posedge clk_i) disable iff (!reset_i)
		data_stall_i |=> ($stable(data_req_o) && $stable(data_we_o) &&
		$stable(data_addr_o) && $stable(data_wdata_o)))
		else $error("data port changed while data_stall_i was high");

endmodule

bind rv_core rv_core_properties u_properties (.*);

`default_nettype wire

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module tb_rv_core;
	import rv_isa_pkg::*;

	localparam int NUM_TESTS    = 5;
	localparam int CYCLE_LIMIT  = 300;
	localparam int RESET_CYCLES = 5;
	localparam int DRAIN_CYCLES = 8; // catches stores after the last expected one
	localparam int WATCHDOG_NS  = NUM_TESTS * (CYCLE_LIMIT + RESET_CYCLES + DRAIN_CYCLES + 2) * 10;

	localparam logic [6:0] OP_LUI  = 7'b0110111;
	localparam logic [6:0] OP_IMM  = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;

	typedef struct packed {
		logic [7:0]        start;     // first program table index
		logic [7:0]        stall_pct; // data stall probability in percent
		logic [7:0]        n_exp;
		logic [0:3][31:0]  addr;
		logic [0:3][31:0]  data;
	} test_row_t;

	logic   clk_i = 1'b0;
	logic   reset_i;
	instr_t instr_i;
	word_t  data_rdata_i;
	logic   data_stall_i;
	word_t  instr_addr_o;
	logic   data_req_o;
	logic   data_we_o;
	word_t  data_addr_o;
	word_t  data_wdata_o;

	instr_t    prog [0:63];
	word_t     dmem [0:63];
	word_t     load_word;   // read data of the last accepted load
	logic [5:0] prog_idx;
	int        cur_start;
	int        cur_pct;
	test_row_t tests [NUM_TESTS];

	always #5 clk_i = ~clk_i;

	rv_core DUT (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.instr_i      (instr_i),
		.data_rdata_i (data_rdata_i),
		.data_stall_i (data_stall_i),
		.instr_addr_o (instr_addr_o),
		.data_req_o   (data_req_o),
		.data_we_o    (data_we_o),
		.data_addr_o  (data_addr_o),
		.data_wdata_o (data_wdata_o)
	);

	rv_core_checker u_checker (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.instr_addr_i (instr_addr_o),
		.data_req_i   (data_req_o),
		.data_we_i    (data_we_o),
		.data_addr_i  (data_addr_o),
		.data_wdata_i (data_wdata_o),
		.data_stall_i (data_stall_i)
	);

	function automatic instr_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic instr_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic instr_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic instr_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic instr_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic instr_t j_type(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// preload value that differs for every word address
	function automatic word_t fill_word(int i);
		return 32'h1000_0000 + word_t'(i) * 32'h0001_0001;
	endfunction

	task automatic build_programs();
		for (int i = 0; i < 64; i++)
			prog[i] = `NOP_INSTR;
		// dependent alu chain
		prog[0]  = u_type(20'h12345, 5'd1, OP_LUI);
		prog[1]  = i_type(12'h678, 5'd1, 3'b000, 5'd2, OP_IMM);
		prog[2]  = r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3);  // add x3,x2,x1
		prog[3]  = r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4);  // sub x4,x3,x2
		prog[4]  = r_type(7'h00, 5'd2, 5'd4, 3'b100, 5'd5);  // xor x5,x4,x2
		prog[5]  = r_type(7'h00, 5'd4, 5'd5, 3'b010, 5'd6);  // slt x6,x5,x4
		prog[6]  = s_type(12'h000, 5'd2, 5'd0);
		prog[7]  = s_type(12'h004, 5'd3, 5'd0);
		prog[8]  = s_type(12'h008, 5'd5, 5'd0);
		prog[9]  = s_type(12'h00c, 5'd6, 5'd0);
		prog[10] = j_type(21'd0, 5'd0);                      // spin
		// load-use
		prog[16] = i_type(12'h040, 5'd0, 3'b000, 5'd1, OP_IMM);
		prog[17] = i_type(12'h000, 5'd1, 3'b010, 5'd2, OP_LOAD);
		prog[18] = r_type(7'h00, 5'd2, 5'd2, 3'b000, 5'd3);
		prog[19] = i_type(12'h004, 5'd1, 3'b010, 5'd4, OP_LOAD);
		prog[20] = i_type(12'h001, 5'd4, 3'b000, 5'd5, OP_IMM);
		prog[21] = s_type(12'h010, 5'd3, 5'd0);
		prog[22] = s_type(12'h014, 5'd5, 5'd0);
		prog[23] = j_type(21'd0, 5'd0);
		// beq taken, bne not taken
		prog[32] = i_type(12'h005, 5'd0, 3'b000, 5'd1, OP_IMM);
		prog[33] = i_type(12'h005, 5'd0, 3'b000, 5'd2, OP_IMM);
		prog[34] = b_type(13'd12, 5'd2, 5'd1, 3'b000);
		prog[35] = s_type(12'h020, 5'd1, 5'd0);              // off path
		prog[36] = s_type(12'h024, 5'd2, 5'd0);              // off path
		prog[37] = i_type(12'h007, 5'd0, 3'b000, 5'd3, OP_IMM);
		prog[38] = b_type(13'd8, 5'd2, 5'd1, 3'b001);
		prog[39] = s_type(12'h028, 5'd3, 5'd0);
		prog[40] = s_type(12'h02c, 5'd1, 5'd0);
		prog[41] = j_type(21'd0, 5'd0);
		// jal with link
		prog[48] = i_type(12'h003, 5'd0, 3'b000, 5'd1, OP_IMM);
		prog[49] = j_type(21'd12, 5'd5);                     // pc 4 -> pc 16
		prog[50] = s_type(12'h030, 5'd1, 5'd0);
		prog[51] = s_type(12'h034, 5'd1, 5'd0);
		prog[52] = s_type(12'h030, 5'd5, 5'd0);
		prog[53] = i_type(12'h00a, 5'd1, 3'b000, 5'd6, OP_IMM);
		prog[54] = s_type(12'h034, 5'd6, 5'd0);
		prog[55] = j_type(21'd0, 5'd0);
	endtask

	// expected stores worked out by hand
	task automatic init_test_table();
		tests[0] = '{start: 8'd0, stall_pct: 8'd0, n_exp: 8'd4,
			addr: {32'h0, 32'h4, 32'h8, 32'hc},
			data: {32'h1234_5678, 32'h2468_a678, 32'h0000_0678, 32'h0000_0001}};
		tests[1] = '{start: 8'd16, stall_pct: 8'd0, n_exp: 8'd2,
			addr: {32'h10, 32'h14, 32'h0, 32'h0},
			data: {32'h2020_0020, 32'h1011_0012, 32'h0, 32'h0}};
		tests[2] = '{start: 8'd32, stall_pct: 8'd0, n_exp: 8'd2,
			addr: {32'h28, 32'h2c, 32'h0, 32'h0},
			data: {32'h7, 32'h5, 32'h0, 32'h0}};
		tests[3] = '{start: 8'd48, stall_pct: 8'd0, n_exp: 8'd2,
			addr: {32'h30, 32'h34, 32'h0, 32'h0},
			data: {32'h8, 32'hd, 32'h0, 32'h0}};
		tests[4] = tests[0];
		tests[4].stall_pct = 8'd30;
	endtask

	// data memory accepting requests at the rising edge
	always @(posedge clk_i)
	begin
		if (!reset_i)
		begin
			for (int i = 0; i < 64; i++)
				dmem[i] = fill_word(i);
		end
		else if (data_req_o && !data_stall_i)
		begin
			if (data_we_o)
				dmem[data_addr_o[7:2]] = data_wdata_o;
			else
				load_word = dmem[data_addr_o[7:2]];
		end
	end

	always @(negedge clk_i)
	begin
		prog_idx     = 6'(cur_start + int'(instr_addr_o[7:2]));
		instr_i      = prog[prog_idx];
		data_rdata_i = load_word; // held until the next load is accepted
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		int cycles;
		int errs;
		int ok_count;
		int bad_count;
		reset_i      = 1'b0;
		instr_i      = `NOP_INSTR;
		data_rdata_i = '0;
		data_stall_i = 1'b0;
		load_word    = '0;
		cur_start    = 0;
		cur_pct      = 0;
		ok_count     = 0;
		bad_count    = 0;
		void'($urandom(32'h79f4));
		build_programs();
		init_test_table();
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			@(negedge clk_i);
			reset_i   = 1'b0;
			cur_start = int'(tests[t].start);
			cur_pct   = int'(tests[t].stall_pct);
			u_checker.clear_expected();
			for (int i = 0; i < int'(tests[t].n_exp); i++)
				u_checker.expect_store(tests[t].addr[i[1:0]], tests[t].data[i[1:0]]);
			repeat (RESET_CYCLES) @(negedge clk_i);
			reset_i = 1'b1;
			cycles = 0;
			while (u_checker.seen < int'(tests[t].n_exp) && cycles < CYCLE_LIMIT)
			begin
				@(negedge clk_i);
				data_stall_i = (cur_pct > 0) && (($urandom % 100) < cur_pct);
				cycles++;
			end
			data_stall_i = 1'b0;
			repeat (DRAIN_CYCLES) @(negedge clk_i);
			u_checker.finish_test(errs);
			if (cycles >= CYCLE_LIMIT)
				$display("test %0d did not complete its stores within %0d cycles", t, CYCLE_LIMIT);
			if (errs == 0)
			begin
				ok_count++;
				$display("test %0d: ok after %0d cycles", t, cycles);
			end
			else
			begin
				bad_count++;
				$display("test %0d: %0d error(s)", t, errs);
			end
		end
		$display("tests run %0d, ok %0d, failing %0d", NUM_TESTS, ok_count, bad_count);
		if (bad_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
